/* hw/cart_mem_port.sv */
module cart_mem_port import gb_sim_pkg::*; (
    input  logic        i_clk_sys,
    input  logic        i_reset,
    // Loader side
    input  logic        i_ioctl_download,
    input  logic [7:0]  i_ioctl_index,
    input  logic        i_ioctl_wr,
    input  ioctl_addr_t i_ioctl_addr,
    input  mem_word_t   i_ioctl_dout,
    output logic        o_ioctl_wait,
    // Play side
    input  logic        i_cart_rd,
    input  mbc_addr_t   i_mbc_addr,
    output rom_byte_t   o_rom_byte,
    output logic        o_rom_valid,
    // Memory side
    output logic        o_mem_req,
    input  logic        i_mem_ack,
    output logic        o_mem_we,
    output mem_addr_t   o_mem_addr,
    output logic [1:0]  o_mem_ds,
    output mem_word_t   o_mem_wdata,
    input  mem_word_t   i_mem_rdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQUEST,
        ST_RELEASE
    } port_state_t;

    port_state_t state;
    logic        cart_download;
    logic        wr_accept;
    logic        rd_accept;
    logic        rd_capture;
    logic        rd_done;
    // Byte select from address bit 0 of the pending read
    logic        rd_sel;
    mem_word_t   rdata_q;

    // Cartridge image downloads only, boot images are ignored
    assign cart_download = i_ioctl_download &&
                           (i_ioctl_index[5:0] == IOCTL_INDEX_CART_LOW ||
                            i_ioctl_index == IOCTL_INDEX_BOOT0 ||
                            i_ioctl_index == IOCTL_INDEX_ALT);

    // One access at a time, taken only from idle
    assign wr_accept  = (state == ST_IDLE) && cart_download && i_ioctl_wr;
    assign rd_accept  = (state == ST_IDLE) && !i_ioctl_download && i_cart_rd;
    assign rd_capture = (state == ST_REQUEST) && i_mem_ack && !o_mem_we;
    assign rd_done    = (state == ST_RELEASE) && !i_mem_ack && !o_mem_we;

    // ==============================
    // Handshake FSM
    // ==============================
    always_ff @(posedge i_clk_sys) begin
        if (i_reset) begin
            state        <= ST_IDLE;
            o_mem_req    <= 1'b0;
            o_mem_we     <= 1'b0;
            o_ioctl_wait <= 1'b0;
            o_rom_valid  <= 1'b0;
        end else begin
            o_rom_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (wr_accept || rd_accept) begin
                        o_mem_req    <= 1'b1;
                        o_mem_we     <= wr_accept;
                        // Hold the loader off until the write lands
                        o_ioctl_wait <= wr_accept;
                        state        <= ST_REQUEST;
                    end
                end
                ST_REQUEST: begin
                    // Drop req as soon as memory answers
                    if (i_mem_ack) begin
                        o_mem_req <= 1'b0;
                        state     <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    // Done once ack is gone again
                    if (!i_mem_ack) begin
                        o_ioctl_wait <= 1'b0;
                        o_rom_valid  <= !o_mem_we;
                        state        <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ==============================
    // Address and data
    // ==============================
    always_ff @(posedge i_clk_sys) begin
        if (wr_accept) begin
            o_mem_addr  <= i_ioctl_addr[24:1];
            o_mem_ds    <= 2'b11;
            o_mem_wdata <= i_ioctl_dout;
        end else if (rd_accept) begin
            o_mem_addr <= {2'b00, i_mbc_addr[22:1]};
            // Odd address reads the high lane
            o_mem_ds   <= {i_mbc_addr[0], ~i_mbc_addr[0]};
            rd_sel     <= i_mbc_addr[0];
        end
        // Read word is only valid while ack is high
        if (rd_capture) begin
            rdata_q <= i_mem_rdata;
        end
        if (rd_done) begin
            o_rom_byte <= rd_sel ? rdata_q[15:8] : rdata_q[7:0];
        end
    end

endmodule

/* hw/gb_clock_enables.sv */
module gb_clock_enables import gb_sim_pkg::*; #(
    parameter int CE_DIV_LOG2 = 4
) (
    input  logic i_clk_sys,
    input  logic i_reset,
    output logic o_ce_cpu,
    output logic o_ce_cpu_n,
    output logic o_ce_cpu2x
);

    // Divider value half way through one CPU period
    localparam logic [CE_DIV_LOG2-1:0] HALF = {1'b1, {(CE_DIV_LOG2-1){1'b0}}};

    logic [CE_DIV_LOG2-1:0] clk_div;
    logic [CE_DIV_LOG2-1:0] clk_div_next;

    // Strobes decode the next count so they line up with the wrap
    assign clk_div_next = clk_div + 1'b1;

    always_ff @(posedge i_clk_sys) begin
        if (i_reset) begin
            clk_div    <= '0;
            o_ce_cpu   <= 1'b0;
            o_ce_cpu_n <= 1'b0;
            o_ce_cpu2x <= 1'b0;
        end else begin
            clk_div    <= clk_div_next;
            // Normal-speed enable once per wrap
            o_ce_cpu   <= (clk_div_next == '0);
            // Opposite phase half a period later
            o_ce_cpu_n <= (clk_div_next == HALF);
            // Double speed on both of the above
            o_ce_cpu2x <= (clk_div_next == '0) || (clk_div_next == HALF);
        end
    end

endmodule

/* hw/gb_sim_pkg.sv */
package gb_sim_pkg;

    // ==============================
    // Video types and codes
    // ==============================

    // Colour-mode LCD pixel, 5 bits per channel, red in the top bits
    typedef logic [14:0] rgb555_t;
    // One 8-bit output channel
    typedef logic [7:0]  color8_t;
    // Monochrome shade index, 0 lightest
    typedef logic [1:0]  dmg_shade_t;
    typedef logic [1:0]  lcd_mode_t;

    localparam lcd_mode_t LCD_MODE_HBLANK = 2'd0;
    localparam lcd_mode_t LCD_MODE_VBLANK = 2'd1;
    // OAM search, used as the idle mode of the video pipe
    localparam lcd_mode_t LCD_MODE_OAM    = 2'd2;

    // Grey levels for the four monochrome shades
    localparam color8_t DMG_SHADE_0 = 8'hff;
    localparam color8_t DMG_SHADE_1 = 8'haa;
    localparam color8_t DMG_SHADE_2 = 8'h55;
    localparam color8_t DMG_SHADE_3 = 8'h00;

    // ==============================
    // Memory types and codes
    // ==============================

    typedef logic [24:0] ioctl_addr_t;
    typedef logic [22:0] mbc_addr_t;
    // Word address into the 16-bit external memory
    typedef logic [23:0] mem_addr_t;
    typedef logic [15:0] mem_word_t;
    typedef logic [7:0]  rom_byte_t;

    // Download index codes for a cartridge image
    // Low six bits only for the first one
    localparam logic [5:0] IOCTL_INDEX_CART_LOW = 6'h01;
    localparam logic [7:0] IOCTL_INDEX_BOOT0    = 8'h00;
    localparam logic [7:0] IOCTL_INDEX_ALT      = 8'h80;

endpackage

/* hw/gb_sim_top.sv */
module gb_sim_top import gb_sim_pkg::*; #(
    parameter int CE_DIV_LOG2 = 4
) (
    input  logic        i_clk_sys,
    input  logic        i_reset,
    // CPU clock enables
    output logic        o_ce_cpu,
    output logic        o_ce_cpu_n,
    output logic        o_ce_cpu2x,
    // Loader
    input  logic        i_ioctl_download,
    input  logic [7:0]  i_ioctl_index,
    input  logic        i_ioctl_wr,
    input  ioctl_addr_t i_ioctl_addr,
    input  mem_word_t   i_ioctl_dout,
    output logic        o_ioctl_wait,
    // Cartridge reads
    input  logic        i_cart_rd,
    input  mbc_addr_t   i_mbc_addr,
    output rom_byte_t   o_rom_byte,
    output logic        o_rom_valid,
    // External word memory
    output logic        o_mem_req,
    input  logic        i_mem_ack,
    output logic        o_mem_we,
    output mem_addr_t   o_mem_addr,
    output logic [1:0]  o_mem_ds,
    output mem_word_t   o_mem_wdata,
    input  mem_word_t   i_mem_rdata,
    // LCD in
    input  logic        i_is_gbc,
    input  rgb555_t     i_lcd_data,
    input  dmg_shade_t  i_lcd_data_gb,
    input  lcd_mode_t   i_lcd_mode,
    input  logic        i_lcd_vsync,
    // Video out
    output color8_t     o_vga_r,
    output color8_t     o_vga_g,
    output color8_t     o_vga_b,
    output logic        o_vga_hs,
    output logic        o_vga_vs,
    output logic        o_vga_hb,
    output logic        o_vga_vb
);

    // Between the two video stages
    color8_t   pix_red;
    color8_t   pix_green;
    color8_t   pix_blue;
    lcd_mode_t pix_mode;
    logic      pix_vsync;

    gb_clock_enables #(
        .CE_DIV_LOG2 (CE_DIV_LOG2)
    ) u_clock_enables (
        .i_clk_sys  (i_clk_sys),
        .i_reset    (i_reset),
        .o_ce_cpu   (o_ce_cpu),
        .o_ce_cpu_n (o_ce_cpu_n),
        .o_ce_cpu2x (o_ce_cpu2x)
    );

    cart_mem_port u_cart_mem_port (
        .i_clk_sys        (i_clk_sys),
        .i_reset          (i_reset),
        .i_ioctl_download (i_ioctl_download),
        .i_ioctl_index    (i_ioctl_index),
        .i_ioctl_wr       (i_ioctl_wr),
        .i_ioctl_addr     (i_ioctl_addr),
        .i_ioctl_dout     (i_ioctl_dout),
        .o_ioctl_wait     (o_ioctl_wait),
        .i_cart_rd        (i_cart_rd),
        .i_mbc_addr       (i_mbc_addr),
        .o_rom_byte       (o_rom_byte),
        .o_rom_valid      (o_rom_valid),
        .o_mem_req        (o_mem_req),
        .i_mem_ack        (i_mem_ack),
        .o_mem_we         (o_mem_we),
        .o_mem_addr       (o_mem_addr),
        .o_mem_ds         (o_mem_ds),
        .o_mem_wdata      (o_mem_wdata),
        .i_mem_rdata      (i_mem_rdata)
    );

    lcd_pixel_stage u_lcd_pixel_stage (
        .i_clk_sys     (i_clk_sys),
        .i_reset       (i_reset),
        .i_is_gbc      (i_is_gbc),
        .i_lcd_data    (i_lcd_data),
        .i_lcd_data_gb (i_lcd_data_gb),
        .i_lcd_mode    (i_lcd_mode),
        .i_lcd_vsync   (i_lcd_vsync),
        .o_red         (pix_red),
        .o_green       (pix_green),
        .o_blue        (pix_blue),
        .o_mode        (pix_mode),
        .o_vsync       (pix_vsync)
    );

    lcd_sync_stage u_lcd_sync_stage (
        .i_clk_sys (i_clk_sys),
        .i_reset   (i_reset),
        .i_red     (pix_red),
        .i_green   (pix_green),
        .i_blue    (pix_blue),
        .i_mode    (pix_mode),
        .i_vsync   (pix_vsync),
        .o_vga_r   (o_vga_r),
        .o_vga_g   (o_vga_g),
        .o_vga_b   (o_vga_b),
        .o_vga_hs  (o_vga_hs),
        .o_vga_vs  (o_vga_vs),
        .o_vga_hb  (o_vga_hb),
        .o_vga_vb  (o_vga_vb)
    );

endmodule

/* hw/lcd_pixel_stage.sv */
module lcd_pixel_stage import gb_sim_pkg::*; (
    input  logic       i_clk_sys,
    input  logic       i_reset,
    input  logic       i_is_gbc,
    input  rgb555_t    i_lcd_data,
    input  dmg_shade_t i_lcd_data_gb,
    input  lcd_mode_t  i_lcd_mode,
    input  logic       i_lcd_vsync,
    output color8_t    o_red,
    output color8_t    o_green,
    output color8_t    o_blue,
    output lcd_mode_t  o_mode,
    output logic       o_vsync
);

    color8_t dmg_gray;

    // Monochrome palette lookup
    always_comb begin
        case (i_lcd_data_gb)
            2'd0:    dmg_gray = DMG_SHADE_0;
            2'd1:    dmg_gray = DMG_SHADE_1;
            2'd2:    dmg_gray = DMG_SHADE_2;
            default: dmg_gray = DMG_SHADE_3;
        endcase
    end

    always_ff @(posedge i_clk_sys) begin
        if (i_reset) begin
            o_red   <= '0;
            o_green <= '0;
            o_blue  <= '0;
            // Non-blank mode so no sync edge comes out of reset
            o_mode  <= LCD_MODE_OAM;
            o_vsync <= 1'b0;
        end else begin
            if (i_is_gbc) begin
                // Top three bits repeated below the 5-bit value
                o_red   <= {i_lcd_data[14:10], i_lcd_data[14:12]};
                o_green <= {i_lcd_data[9:5], i_lcd_data[9:7]};
                o_blue  <= {i_lcd_data[4:0], i_lcd_data[4:2]};
            end else begin
                o_red   <= dmg_gray;
                o_green <= dmg_gray;
                o_blue  <= dmg_gray;
            end
            // Timing codes travel with the pixel
            o_mode  <= i_lcd_mode;
            o_vsync <= i_lcd_vsync;
        end
    end

endmodule

/* hw/lcd_sync_stage.sv */
module lcd_sync_stage import gb_sim_pkg::*; (
    input  logic      i_clk_sys,
    input  logic      i_reset,
    input  color8_t   i_red,
    input  color8_t   i_green,
    input  color8_t   i_blue,
    input  lcd_mode_t i_mode,
    input  logic      i_vsync,
    output color8_t   o_vga_r,
    output color8_t   o_vga_g,
    output color8_t   o_vga_b,
    output logic      o_vga_hs,
    output logic      o_vga_vs,
    output logic      o_vga_hb,
    output logic      o_vga_vb
);

    logic in_hblank;
    logic in_vblank;
    // HBlank state of the previous input cycle
    logic last_hblank;

    assign in_hblank = (i_mode == LCD_MODE_HBLANK);
    assign in_vblank = (i_mode == LCD_MODE_VBLANK);

    always_ff @(posedge i_clk_sys) begin
        if (i_reset) begin
            last_hblank <= 1'b0;
            // Syncs idle high, blanks idle low
            o_vga_hs    <= 1'b1;
            o_vga_vs    <= 1'b1;
            o_vga_hb    <= 1'b0;
            o_vga_vb    <= 1'b0;
            o_vga_r     <= '0;
            o_vga_g     <= '0;
            o_vga_b     <= '0;
        end else begin
            last_hblank <= in_hblank;
            // Low for one cycle on HBlank entry
            o_vga_hs    <= !(in_hblank && !last_hblank);
            // LCD vsync is active high
            o_vga_vs    <= ~i_vsync;
            o_vga_hb    <= in_hblank;
            o_vga_vb    <= in_vblank;
            // Pixel delayed to line up with the sync outputs
            o_vga_r     <= i_red;
            o_vga_g     <= i_green;
            o_vga_b     <= i_blue;
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then search the log for the result
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module tb_gb_sim_top -o Vtb_gb_sim_top \
    && ./obj_dir/Vtb_gb_sim_top > sim.log 2>&1

grep -qx ">>> PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* tb/gb_sim_assertions.sv */
module gb_sim_assertions #(
    parameter bit CHECK_HANDSHAKE = 1'b1,
    parameter bit CHECK_SYNC      = 1'b1
) (
    input logic i_clk_sys,
    input logic i_reset,
    input logic i_mem_req,
    input logic i_mem_ack,
    input logic i_vga_hs
);

    // ==============================
    // Four-phase memory handshake
    // ==============================

    if (CHECK_HANDSHAKE) begin : g_handshake
        // A new request waits for ack to be low
        assert property (@(posedge i_clk_sys) disable iff (i_reset)
            $rose(i_mem_req) |-> !i_mem_ack)
        else $error("req rose while ack was still high");

        // Request held until memory answers
        assert property (@(posedge i_clk_sys) disable iff (i_reset)
            (i_mem_req && !i_mem_ack) |=> i_mem_req)
        else $error("req dropped before ack");
    end

    // ==============================
    // Sync outputs
    // ==============================

    if (CHECK_SYNC) begin : g_sync
        // HBlank entry pulse is a single cycle
        assert property (@(posedge i_clk_sys) disable iff (i_reset)
            !i_vga_hs |=> i_vga_hs)
        else $error("hsync low for two cycles in a row");
    end

endmodule

// Handshake checks on the memory port
bind cart_mem_port gb_sim_assertions #(
    .CHECK_HANDSHAKE (1'b1),
    .CHECK_SYNC      (1'b0)
) u_port_assertions (
    .i_clk_sys (i_clk_sys),
    .i_reset   (i_reset),
    .i_mem_req (o_mem_req),
    .i_mem_ack (i_mem_ack),
    .i_vga_hs  (1'b1)
);

// Sync checks on the video output stage
bind lcd_sync_stage gb_sim_assertions #(
    .CHECK_HANDSHAKE (1'b0),
    .CHECK_SYNC      (1'b1)
) u_sync_assertions (
    .i_clk_sys (i_clk_sys),
    .i_reset   (i_reset),
    .i_mem_req (1'b0),
    .i_mem_ack (1'b0),
    .i_vga_hs  (o_vga_hs)
);

/* tb/gb_sim_testdata.txt */
# P mode vsync gbc rgb555 shade exp_r exp_g exp_b
# W index byte_addr data   R mbc_addr exp_byte   (all hex)
P 2 0 1 7FFF 0 FF FF FF
P 2 0 1 0000 0 00 00 00
P 3 0 1 7C00 0 FF 00 00
P 3 0 1 03E0 0 00 FF 00
P 0 0 1 001F 0 00 00 FF
P 0 0 1 4210 0 84 84 84
P 0 0 0 0000 1 AA AA AA
P 2 0 0 0000 0 FF FF FF
P 3 0 0 0000 2 55 55 55
P 0 0 0 0000 3 00 00 00
P 1 1 1 1234 0 21 8C A5
P 1 1 0 0000 1 AA AA AA
W 01 000000 3412
W 01 000002 7856
W 41 000004 BC9A
W 80 000006 F0DE
W 00 000008 1122
W 02 00000A DEAD
W 3F 00000C BEEF
R 000000 12
R 000001 34
R 000003 78
R 000002 56
R 000004 9A
R 000005 BC
R 000007 F0
R 000008 22
R 000009 11

/* tb/tb_gb_sim_top.sv */
module tb_gb_sim_top import gb_sim_pkg::*; ();

    localparam int CE_DIV_LOG2 = 4;
    localparam int CE_N        = 1 << CE_DIV_LOG2;
    localparam int MAX_LINES   = 64;

    logic clk_sys;
    logic i_reset;
    logic i_ioctl_download, i_ioctl_wr, i_cart_rd, i_mem_ack, i_is_gbc, i_lcd_vsync;
    logic [7:0] i_ioctl_index;
    ioctl_addr_t i_ioctl_addr;
    mem_word_t i_ioctl_dout, i_mem_rdata;
    mbc_addr_t i_mbc_addr;
    rgb555_t i_lcd_data;
    dmg_shade_t i_lcd_data_gb;
    lcd_mode_t i_lcd_mode;
    logic o_ce_cpu, o_ce_cpu_n, o_ce_cpu2x, o_ioctl_wait, o_rom_valid;
    logic o_mem_req, o_mem_we, o_vga_hs, o_vga_vs, o_vga_hb, o_vga_vb;
    logic [1:0] o_mem_ds;
    rom_byte_t o_rom_byte;
    mem_addr_t o_mem_addr;
    mem_word_t o_mem_wdata;
    color8_t o_vga_r, o_vga_g, o_vga_b;

    // One tag and up to eight fields per vector line
    string kind [0:MAX_LINES-1];
    logic [31:0] fld [0:MAX_LINES-1][0:7];
    int n_lines, errors, checks, cycle_count, cycle_limit, ce_cnt, req_count, wr_count;
    logic prev_req;
    // Expected strobes from the divide ratio
    logic exp_ce_cpu, exp_ce_cpu_n;
    // Word memory behind the handshake
    mem_word_t mem [mem_addr_t];
    mem_addr_t last_wr_addr;
    mem_word_t last_wr_data;
    logic [1:0] last_wr_ds;
    // Expected pixel that travels with the driven inputs
    color8_t drv_r, drv_g, drv_b;
    logic drv_valid;
    // Video model stage 1 and stage 2 registers
    lcd_mode_t s1_mode;
    logic s1_vsync, s1_valid, s2_hb, s2_vb, s2_vs, s2_hs, s2_valid;
    color8_t s1_r, s1_g, s1_b, s2_r, s2_g, s2_b;

    gb_sim_top #(.CE_DIV_LOG2(CE_DIV_LOG2)) i_dut (
        .i_clk_sys(clk_sys), .i_reset(i_reset),
        .o_ce_cpu(o_ce_cpu), .o_ce_cpu_n(o_ce_cpu_n), .o_ce_cpu2x(o_ce_cpu2x),
        .i_ioctl_download(i_ioctl_download), .i_ioctl_index(i_ioctl_index),
        .i_ioctl_wr(i_ioctl_wr), .i_ioctl_addr(i_ioctl_addr), .i_ioctl_dout(i_ioctl_dout),
        .o_ioctl_wait(o_ioctl_wait), .i_cart_rd(i_cart_rd), .i_mbc_addr(i_mbc_addr),
        .o_rom_byte(o_rom_byte), .o_rom_valid(o_rom_valid), .o_mem_req(o_mem_req),
        .i_mem_ack(i_mem_ack), .o_mem_we(o_mem_we), .o_mem_addr(o_mem_addr),
        .o_mem_ds(o_mem_ds), .o_mem_wdata(o_mem_wdata), .i_mem_rdata(i_mem_rdata),
        .i_is_gbc(i_is_gbc), .i_lcd_data(i_lcd_data), .i_lcd_data_gb(i_lcd_data_gb),
        .i_lcd_mode(i_lcd_mode), .i_lcd_vsync(i_lcd_vsync),
        .o_vga_r(o_vga_r), .o_vga_g(o_vga_g), .o_vga_b(o_vga_b), .o_vga_hs(o_vga_hs),
        .o_vga_vs(o_vga_vs), .o_vga_hb(o_vga_hb), .o_vga_vb(o_vga_vb)
    );

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("error: %s", what);
    endtask

    // ==============================
    // Run limit
    // ==============================
    always @(posedge clk_sys) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish in %0d cycles, %0d errors so far",
                     cycle_limit, errors);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ==============================
    // Clock enable model
    // ==============================
    always @(posedge clk_sys) begin
        if (i_reset)
            ce_cnt <= 0;
        else
            ce_cnt <= ce_cnt + 1;
    end

    always @(negedge clk_sys) begin
        // First strobe N cycles after reset release and the opposite phase N/2 later
        exp_ce_cpu   = (ce_cnt != 0) && (ce_cnt % CE_N == 0);
        exp_ce_cpu_n = (ce_cnt % CE_N == CE_N / 2);
        if (cycle_count > 0) begin
            check_value("o_ce_cpu", o_ce_cpu, exp_ce_cpu);
            check_value("o_ce_cpu_n", o_ce_cpu_n, exp_ce_cpu_n);
            check_value("o_ce_cpu2x", o_ce_cpu2x, exp_ce_cpu | exp_ce_cpu_n);
        end
    end

    // ==============================
    // Memory responder
    // ==============================
    always @(posedge clk_sys) begin
        if (o_mem_req === 1'b1 && prev_req !== 1'b1)
            req_count++;
        prev_req <= o_mem_req;
    end

    initial begin
        int delay;
        mem_word_t word;
        void'($urandom(32'hf7b8282e));
        forever begin
            @(posedge clk_sys);
            if (o_mem_req === 1'b1 && i_mem_ack === 1'b0) begin
                delay = $urandom_range(4, 1);
                repeat (delay - 1) @(posedge clk_sys);
                // Fill pattern for words never written
                word = mem.exists(o_mem_addr) ? mem[o_mem_addr] :
                       o_mem_addr[15:0] ^ {o_mem_addr[23:16], o_mem_addr[23:16]};
                if (o_mem_we) begin
                    if (o_mem_ds[1])
                        word[15:8] = o_mem_wdata[15:8];
                    if (o_mem_ds[0])
                        word[7:0] = o_mem_wdata[7:0];
                    mem[o_mem_addr] = word;
                    last_wr_addr = o_mem_addr;
                    last_wr_data = o_mem_wdata;
                    last_wr_ds = o_mem_ds;
                    wr_count++;
                end
                i_mem_ack <= 1'b1;
                i_mem_rdata <= word;
                @(posedge clk_sys);
                while (o_mem_req)
                    @(posedge clk_sys);
                delay = $urandom_range(4, 1);
                repeat (delay - 1) @(posedge clk_sys);
                i_mem_ack <= 1'b0;
            end
        end
    end

    // ==============================
    // Two-stage video model
    // ==============================
    always @(posedge clk_sys) begin
        if (i_reset) begin
            s1_mode <= LCD_MODE_OAM;
            s1_vsync <= 1'b0;
            s1_valid <= 1'b0;
            s2_hb <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_mode <= i_lcd_mode;
            s1_vsync <= i_lcd_vsync;
            s1_valid <= drv_valid;
            {s1_r, s1_g, s1_b} <= {drv_r, drv_g, drv_b};
            s2_hb <= (s1_mode == LCD_MODE_HBLANK);
            s2_vb <= (s1_mode == LCD_MODE_VBLANK);
            s2_vs <= !s1_vsync;
            // Sync low only on the first HBlank cycle of a run
            s2_hs <= !(s1_mode == LCD_MODE_HBLANK && !s2_hb);
            s2_valid <= s1_valid;
            {s2_r, s2_g, s2_b} <= {s1_r, s1_g, s1_b};
        end
    end

    always @(negedge clk_sys) begin
        if (s2_valid && !i_reset) begin
            check_value("o_vga_r", o_vga_r, s2_r);
            check_value("o_vga_g", o_vga_g, s2_g);
            check_value("o_vga_b", o_vga_b, s2_b);
            check_value("o_vga_hs", o_vga_hs, s2_hs);
            check_value("o_vga_vs", o_vga_vs, s2_vs);
            check_value("o_vga_hb", o_vga_hb, s2_hb);
            check_value("o_vga_vb", o_vga_vb, s2_vb);
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    task automatic read_vectors();
        int fd, n;
        string line, tag;
        logic [31:0] f [0:7];
        fd = $fopen("tb/gb_sim_testdata.txt", "r");
        if (fd == 0) begin
            report_failure("could not open the test data file");
            return;
        end
        while (!$feof(fd) && n_lines < MAX_LINES) begin
            line = "";
            if ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", tag,
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                if (n > 1 && tag != "#") begin
                    kind[n_lines] = tag;
                    for (int k = 0; k < 8; k++)
                        fld[n_lines][k] = f[k];
                    n_lines++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_pixel(input int i);
        @(posedge clk_sys);
        i_lcd_mode <= fld[i][0][1:0];
        i_lcd_vsync <= fld[i][1][0];
        i_is_gbc <= fld[i][2][0];
        i_lcd_data <= fld[i][3][14:0];
        i_lcd_data_gb <= fld[i][4][1:0];
        drv_r <= fld[i][5][7:0];
        drv_g <= fld[i][6][7:0];
        drv_b <= fld[i][7][7:0];
        drv_valid <= 1'b1;
    endtask

    task automatic drive_video_idle();
        @(posedge clk_sys);
        i_lcd_mode <= LCD_MODE_OAM;
        i_lcd_vsync <= 1'b0;
        drv_valid <= 1'b0;
    endtask

    task automatic download_write(input int i);
        int reqs_before, wrs_before;
        logic cart;
        cart = fld[i][0][5:0] == 6'h01 || fld[i][0][7:0] == 8'h00 || fld[i][0][7:0] == 8'h80;
        reqs_before = req_count;
        wrs_before = wr_count;
        @(posedge clk_sys);
        i_ioctl_download <= 1'b1;
        i_ioctl_index <= fld[i][0][7:0];
        i_ioctl_addr <= fld[i][1][24:0];
        i_ioctl_dout <= fld[i][2][15:0];
        i_ioctl_wr <= 1'b1;
        @(posedge clk_sys);
        i_ioctl_wr <= 1'b0;
        @(negedge clk_sys);
        if (cart) begin
            check_value("o_ioctl_wait", o_ioctl_wait, 1'b1);
            while (o_ioctl_wait)
                @(negedge clk_sys);
            check_value("write count", wr_count, wrs_before + 1);
            check_value("o_mem_addr", last_wr_addr, fld[i][1][24:1]);
            check_value("o_mem_wdata", last_wr_data, fld[i][2][15:0]);
            check_value("o_mem_ds", last_wr_ds, 2'b11);
        end else begin
            repeat (8) @(negedge clk_sys);
            if (req_count != reqs_before)
                report_failure("a download with a non-cartridge index raised a request");
        end
        @(posedge clk_sys);
        i_ioctl_download <= 1'b0;
    endtask

    task automatic rom_read(input int i);
        @(posedge clk_sys);
        i_cart_rd <= 1'b1;
        i_mbc_addr <= fld[i][0][22:0];
        @(posedge clk_sys);
        i_cart_rd <= 1'b0;
        @(negedge clk_sys);
        while (!o_rom_valid)
            @(negedge clk_sys);
        check_value("o_rom_byte", o_rom_byte, fld[i][1][7:0]);
        @(negedge clk_sys);
        if (o_rom_valid)
            report_failure("o_rom_valid stayed high for more than one cycle");
    endtask

    initial begin
        i_reset = 1'b1;
        {i_ioctl_download, i_ioctl_wr, i_cart_rd, i_mem_ack, i_is_gbc, i_lcd_vsync} = '0;
        i_ioctl_index = '0;
        i_ioctl_addr = '0;
        i_ioctl_dout = '0;
        i_mem_rdata = '0;
        i_mbc_addr = '0;
        i_lcd_data = '0;
        i_lcd_data_gb = '0;
        i_lcd_mode = LCD_MODE_OAM;
        drv_valid = 1'b0;
        read_vectors();
        cycle_limit = 64 * n_lines + 200;
        repeat (2) @(posedge clk_sys);
        i_reset <= 1'b0;
        for (int i = 0; i < n_lines; i++) begin
            if (kind[i] == "P") begin
                drive_pixel(i);
                if (i + 1 == n_lines || kind[i + 1] != "P")
                    drive_video_idle();
            end else if (kind[i] == "W") begin
                download_write(i);
            end else if (kind[i] == "R") begin
                rom_read(i);
            end
        end
        // Let the video pipe and the enable checks run a little longer
        repeat (2 * CE_N) @(posedge clk_sys);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && n_lines > 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* verilog.f */
hw/gb_sim_pkg.sv
hw/gb_clock_enables.sv
hw/cart_mem_port.sv
hw/lcd_pixel_stage.sv
hw/lcd_sync_stage.sv
hw/gb_sim_top.sv
tb/gb_sim_assertions.sv
tb/tb_gb_sim_top.sv
